// File: hw/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// widths shared by the decode stage and its neighbours

// machine address width
// pc, jump targets and the predicted target all use it
`define M_WIDTH 32

// pattern history table index
// carried through decode untouched, back to the predictor
// on branch resolution
`define LG_PHT_SZ 12

// physical register index width
// 64 entries in the prf
// architectural numbers are only 5 bits
// and get zero extended up to this width
`define LG_PRF_ENTRIES 6

// the split of a jump target inside the micro-op
// low 16 bits ride in imm, the rest in jmp_imm
// so M_WIDTH has to stay above 16

`endif

// File: hw/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

	// physical register index
	typedef logic [`LG_PRF_ENTRIES-1:0] preg_t;

	// rv32i major opcodes
	localparam logic [6:0] OPC_LOAD   = 7'h03;
	localparam logic [6:0] OPC_OP_IMM = 7'h13;
	localparam logic [6:0] OPC_AUIPC  = 7'h17;
	localparam logic [6:0] OPC_STORE  = 7'h23;
	localparam logic [6:0] OPC_OP     = 7'h33;
	localparam logic [6:0] OPC_LUI    = 7'h37;
	localparam logic [6:0] OPC_BRANCH = 7'h63;
	localparam logic [6:0] OPC_JALR   = 7'h67;
	localparam logic [6:0] OPC_JAL    = 7'h6f;
	localparam logic [6:0] OPC_SYSTEM = 7'h73;

	// the six instruction formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	// b-type scrambles the offset, bit 0 is implied zero
	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// j-type, same idea as b-type but 21 bit offset
	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one fetched word, read through whichever format applies
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} rv_insn_t;

	// micro-op codes
	// II must stay zero, an all-zero uop is the illegal op
	typedef enum logic [5:0] {
		II = 6'd0,
		NOP,
		LB, LH, LW, LBU, LHU,
		SB, SH, SW,
		ADDI, XORI, ORI, ANDI,
		ADDU, SLL, XOR,
		AUIPC, LUI,
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		JAL, J, JALR, JR,
		BREAK
	} op_t;

	typedef struct packed {
		op_t                    op;
		preg_t                  srcA;
		logic                   srcA_valid;
		preg_t                  srcB;
		logic                   srcB_valid;
		preg_t                  dst;
		logic                   dst_valid;
		// predicted jalr target lives in imm and jmp_imm
		logic [15:0]            imm;
		logic [`M_WIDTH-17:0]   jmp_imm;
		logic [31:0]            rvimm;
		logic [`M_WIDTH-1:0]    pc;
		logic [`LG_PHT_SZ-1:0]  pht_idx;
		logic                   serializing_op;
		logic                   br_pred;
		logic                   is_br;
		logic                   is_mem;
		logic                   is_int;
		logic                   is_store;
	} uop_t;

	// arch register number into prf index width
	function automatic preg_t to_preg(input logic [4:0] areg);
		to_preg = {{(`LG_PRF_ENTRIES-5){1'b0}}, areg};
	endfunction

endpackage

// File: hw/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen
(
	input  decode_pkg::rv_insn_t insn,
	output logic [31:0]          rvimm
);
	import decode_pkg::*;

	logic [6:0]  opcode;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	// opcode sits in the same place in every format
	assign opcode = insn.r_fmt.opcode;

	// loads, op-imm, jalr
	assign imm_i = {{20{insn.i_fmt.imm_11_0[11]}}, insn.i_fmt.imm_11_0};

	// stores, offset split around rs2
	assign imm_s = {{20{insn.s_fmt.imm_11_5[6]}}, insn.s_fmt.imm_11_5, insn.s_fmt.imm_4_0};

	// branches
	// halfword offset so bit 0 is always zero
	assign imm_b = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
			insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};

	// lui and auipc, upper 20 bits only
	assign imm_u = {insn.u_fmt.imm_31_12, 12'd0};

	// jal, again halfword aligned
	assign imm_j = {{11{insn.j_fmt.imm_20}}, insn.j_fmt.imm_20, insn.j_fmt.imm_19_12,
			insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};

	// pick by major opcode only
	// funct fields do not matter here
	always_comb
	begin
		case (opcode)
			OPC_LOAD, OPC_OP_IMM, OPC_JALR:
				rvimm = imm_i;
			OPC_STORE:
				rvimm = imm_s;
			OPC_BRANCH:
				rvimm = imm_b;
			OPC_LUI, OPC_AUIPC:
				rvimm = imm_u;
			OPC_JAL:
				rvimm = imm_j;
			// register ops, system and anything unknown
			default:
				rvimm = 32'd0;
		endcase
	end

endmodule

// File: hw/rv_op_decode.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module rv_op_decode
(
	input  decode_pkg::rv_insn_t  insn,
	input  logic [`M_WIDTH-1:0]   pred_target,
	output decode_pkg::uop_t      fields
);
	import decode_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	preg_t      rd;
	preg_t      rs1;
	preg_t      rs2;
	logic       rd_nz;
	logic       sys_zero;
	// result producing class, folds to NOP when rd is x0
	logic       writes_rd;
	uop_t       dec;

	// field positions shared by every format
	assign opcode = insn.r_fmt.opcode;
	assign funct3 = insn.r_fmt.funct3;
	assign funct7 = insn.r_fmt.funct7;

	// arch regs into prf index width
	assign rd  = to_preg(insn.r_fmt.rd);
	assign rs1 = to_preg(insn.r_fmt.rs1);
	assign rs2 = to_preg(insn.r_fmt.rs2);

	assign rd_nz = (insn.r_fmt.rd != 5'd0);

	// bits 31..7 all clear, i.e. ecall/ebreak style word with nothing set
	assign sys_zero = (insn.u_fmt.imm_31_12 == 20'd0) && (insn.u_fmt.rd == 5'd0);

	always_comb
	begin
		dec = '0;
		dec.op = II;
		writes_rd = 1'b0;
		case (opcode)
			OPC_LOAD:
			begin
				dec.dst = rd;
				dec.srcA = rs1;
				dec.dst_valid = rd_nz;
				// base register only needed if the load survives
				dec.srcA_valid = rd_nz;
				dec.is_mem = 1'b1;
				writes_rd = 1'b1;
				case (funct3)
					3'd0: dec.op = LB;
					3'd1: dec.op = LH;
					3'd2: dec.op = LW;
					3'd4: dec.op = LBU;
					3'd5: dec.op = LHU;
					default: dec.op = II;
				endcase
			end
			OPC_OP_IMM:
			begin
				dec.dst = rd;
				dec.srcA = rs1;
				dec.dst_valid = rd_nz;
				dec.srcA_valid = rd_nz;
				dec.is_int = 1'b1;
				writes_rd = 1'b1;
				// no slti/sltiu or shifts by immediate yet
				case (funct3)
					3'd0: dec.op = ADDI;
					3'd4: dec.op = XORI;
					3'd6: dec.op = ORI;
					3'd7: dec.op = ANDI;
					default: dec.op = II;
				endcase
			end
			OPC_STORE:
			begin
				dec.srcA = rs1;
				dec.srcB = rs2;
				dec.srcA_valid = 1'b1;
				dec.srcB_valid = 1'b1;
				dec.is_mem = 1'b1;
				dec.is_store = 1'b1;
				case (funct3)
					3'd0: dec.op = SB;
					3'd1: dec.op = SH;
					3'd2: dec.op = SW;
					default: dec.op = II;
				endcase
			end
			OPC_OP:
			begin
				dec.dst = rd;
				dec.dst_valid = rd_nz;
				// both sources read even if the result is dropped
				dec.srcA = rs1;
				dec.srcB = rs2;
				dec.srcA_valid = 1'b1;
				dec.srcB_valid = 1'b1;
				dec.is_int = 1'b1;
				writes_rd = 1'b1;
				// only the base encodings, funct7 zero
				if (funct7 == 7'd0)
				begin
					case (funct3)
						3'd0: dec.op = ADDU;
						3'd1: dec.op = SLL;
						3'd4: dec.op = XOR;
						default: dec.op = II;
					endcase
				end
			end
			OPC_AUIPC, OPC_LUI:
			begin
				dec.op = (opcode == OPC_LUI) ? LUI : AUIPC;
				dec.dst = rd;
				dec.dst_valid = rd_nz;
				dec.is_int = 1'b1;
				writes_rd = 1'b1;
			end
			OPC_BRANCH:
			begin
				dec.srcA = rs1;
				dec.srcB = rs2;
				dec.srcA_valid = 1'b1;
				dec.srcB_valid = 1'b1;
				// conditional branches resolve by op in the alu
				dec.is_int = 1'b1;
				case (funct3)
					3'd0: dec.op = BEQ;
					3'd1: dec.op = BNE;
					3'd4: dec.op = BLT;
					3'd5: dec.op = BGE;
					3'd6: dec.op = BLTU;
					3'd7: dec.op = BGEU;
					default: dec.op = II;
				endcase
			end
			OPC_JALR:
			begin
				dec.srcA = rs1;
				dec.srcA_valid = 1'b1;
				dec.is_int = 1'b1;
				dec.is_br = 1'b1;
				// predicted target split across imm and jmp_imm
				dec.imm = pred_target[15:0];
				dec.jmp_imm = pred_target[`M_WIDTH-1:16];
				if (rd_nz)
				begin
					dec.op = JALR;
					dec.dst = rd;
					dec.dst_valid = 1'b1;
				end
				else
					dec.op = JR;
			end
			OPC_JAL:
			begin
				// direct jump, always predicted taken
				dec.br_pred = 1'b1;
				dec.is_br = 1'b1;
				dec.is_int = 1'b1;
				if (rd_nz)
				begin
					dec.op = JAL;
					dec.dst = rd;
					dec.dst_valid = 1'b1;
				end
				else
					dec.op = J;
			end
			OPC_SYSTEM:
			begin
				dec.is_int = 1'b1;
				// the all-zero system word stops the machine
				// everything else in this space is ignored
				if (sys_zero)
				begin
					dec.op = BREAK;
					dec.serializing_op = 1'b1;
				end
				else
					dec.op = NOP;
			end
			default:
				dec.op = II;
		endcase

		// x0 destination, nothing to compute
		if (writes_rd && !rd_nz && dec.op != II)
			dec.op = NOP;

		// illegal op leaves no trace in the other fields
		if (dec.op == II)
			dec = '0;
	end

	assign fields = dec;

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   insn_valid,
	input  logic [31:0]            insn,
	input  logic [`M_WIDTH-1:0]    pc,
	input  logic [`LG_PHT_SZ-1:0]  pht_idx,
	input  logic [`M_WIDTH-1:0]    pred_target,
	output logic                   uop_valid,
	output decode_pkg::uop_t       uop
);
	import decode_pkg::*;

	rv_insn_t    insn_u;
	uop_t        fields;
	logic [31:0] rvimm;
	uop_t        uop_next;

	// same word seen through the format views
	assign insn_u = rv_insn_t'(insn);

	// op, registers and class flags
	rv_op_decode i_op_decode
	(
		.insn        (insn_u),
		.pred_target (pred_target),
		.fields      (fields)
	);

	// sign extended immediate
	rv_imm_gen i_imm_gen
	(
		.insn  (insn_u),
		.rvimm (rvimm)
	);

	// merge both decoders with the fetch metadata
	always_comb
	begin
		uop_next = fields;
		uop_next.rvimm = rvimm;
		uop_next.pc = pc;
		uop_next.pht_idx = pht_idx;
	end

	// one cycle through decode
	// a bubble drops valid but keeps the last uop
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			uop_valid <= 1'b0;
			uop <= '0;
		end
		else
		begin
			uop_valid <= insn_valid;
			if (insn_valid)
			begin
				uop <= uop_next;
			end
		end
	end

endmodule

// File: bench/decode_asserts.sv
`timescale 1ns/1ps

module decode_asserts
(
	input logic              clk,
	input logic              rst_n,
	input logic              uop_valid,
	input decode_pkg::uop_t  uop
);
	import decode_pkg::*;

	// nothing leaves decode while reset is held
	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !uop_valid)
		else $error("uop_valid high while rst_n is low");

	// every store goes through the memory pipe
	a_store_is_mem: assert property (@(posedge clk) disable iff (!rst_n) uop.is_store |-> uop.is_mem)
		else $error("store micro-op without is_mem");

	// x0 is never renamed
	a_dst_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		uop.dst_valid |-> (uop.dst != '0))
		else $error("valid destination pointing at register zero");

	// illegal op carries no register traffic
	a_ii_no_valids: assert property (@(posedge clk) disable iff (!rst_n)
		(uop.op == II) |-> !(uop.srcA_valid || uop.srcB_valid || uop.dst_valid))
		else $error("illegal op with a register valid flag set");

endmodule

bind decode_stage decode_asserts i_decode_asserts
(
	.clk       (clk),
	.rst_n     (rst_n),
	.uop_valid (uop_valid),
	.uop       (uop)
);

// File: bench/tb_decode_stage.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module tb_decode_stage;
	import decode_pkg::*;

	logic                  clk;
	logic                  rst_n;
	logic                  insn_valid;
	logic [31:0]           insn;
	logic [`M_WIDTH-1:0]   pc;
	logic [`LG_PHT_SZ-1:0] pht_idx;
	logic [`M_WIDTH-1:0]   pred_target;
	logic                  uop_valid;
	uop_t                  uop;

	uop_t        exp_q[$];
	uop_t        exp_uop;
	// last micro-op that left decode, all zero out of reset
	uop_t        held_uop;
	logic        exp_valid;
	logic [31:0] lfsr_q;

	decode_stage i_decode_stage
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.insn_valid  (insn_valid),
		.insn        (insn),
		.pc          (pc),
		.pht_idx     (pht_idx),
		.pred_target (pred_target),
		.uop_valid   (uop_valid),
		.uop         (uop)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit with the msb taken first
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("** Error %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	function automatic logic [6:0] kept_opcode(input logic [3:0] sel);
		case (sel)
			4'd0: kept_opcode = OPC_LOAD;
			4'd1: kept_opcode = OPC_OP_IMM;
			4'd2: kept_opcode = OPC_AUIPC;
			4'd3: kept_opcode = OPC_STORE;
			4'd4: kept_opcode = OPC_OP;
			4'd5: kept_opcode = OPC_LUI;
			4'd6: kept_opcode = OPC_BRANCH;
			4'd7: kept_opcode = OPC_JALR;
			4'd8: kept_opcode = OPC_JAL;
			default: kept_opcode = OPC_SYSTEM;
		endcase
	endfunction

	// immediate straight from the rv32i bit layout
	function automatic logic [31:0] imm_ref(input logic [31:0] w);
		case (w[6:0])
			OPC_LOAD, OPC_OP_IMM, OPC_JALR: imm_ref = {{20{w[31]}}, w[31:20]};
			OPC_STORE: imm_ref = {{20{w[31]}}, w[31:25], w[11:7]};
			OPC_BRANCH: imm_ref = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			OPC_LUI, OPC_AUIPC: imm_ref = {w[31:12], 12'd0};
			OPC_JAL: imm_ref = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			default: imm_ref = '0;
		endcase
	endfunction

	// expected micro-op for one fetched word
	function automatic uop_t decode_ref(input logic [31:0] w, input logic [`M_WIDTH-1:0] fpc,
			input logic [`LG_PHT_SZ-1:0] pht, input logic [`M_WIDTH-1:0] pt);
		uop_t u;
		logic rd_nz;
		logic writes;
		u = '0;
		u.op = II;
		rd_nz = (w[11:7] != 5'd0);
		writes = 1'b0;
		case (w[6:0])
			OPC_LOAD:
			begin
				u.op = (w[14:12] == 3'd0) ? LB : (w[14:12] == 3'd1) ? LH : (w[14:12] == 3'd2) ? LW :
					(w[14:12] == 3'd4) ? LBU : (w[14:12] == 3'd5) ? LHU : II;
				{u.dst, u.dst_valid, u.srcA, u.srcA_valid} = {preg_t'(w[11:7]), rd_nz,
					preg_t'(w[19:15]), rd_nz};
				u.is_mem = 1'b1;
				writes = 1'b1;
			end
			OPC_OP_IMM:
			begin
				u.op = (w[14:12] == 3'd0) ? ADDI : (w[14:12] == 3'd4) ? XORI :
					(w[14:12] == 3'd6) ? ORI : (w[14:12] == 3'd7) ? ANDI : II;
				{u.dst, u.dst_valid, u.srcA, u.srcA_valid} = {preg_t'(w[11:7]), rd_nz,
					preg_t'(w[19:15]), rd_nz};
				u.is_int = 1'b1;
				writes = 1'b1;
			end
			OPC_STORE:
			begin
				u.op = (w[14:12] == 3'd0) ? SB : (w[14:12] == 3'd1) ? SH :
					(w[14:12] == 3'd2) ? SW : II;
				{u.srcA, u.srcA_valid, u.srcB, u.srcB_valid} = {preg_t'(w[19:15]), 1'b1,
					preg_t'(w[24:20]), 1'b1};
				{u.is_mem, u.is_store} = 2'b11;
			end
			OPC_OP:
			begin
				if (w[31:25] == 7'd0)
					u.op = (w[14:12] == 3'd0) ? ADDU : (w[14:12] == 3'd1) ? SLL :
						(w[14:12] == 3'd4) ? XOR : II;
				{u.srcA, u.srcA_valid, u.srcB, u.srcB_valid} = {preg_t'(w[19:15]), 1'b1,
					preg_t'(w[24:20]), 1'b1};
				{u.dst, u.dst_valid, u.is_int} = {preg_t'(w[11:7]), rd_nz, 1'b1};
				writes = 1'b1;
			end
			OPC_AUIPC, OPC_LUI:
			begin
				u.op = (w[6:0] == OPC_LUI) ? LUI : AUIPC;
				{u.dst, u.dst_valid, u.is_int} = {preg_t'(w[11:7]), rd_nz, 1'b1};
				writes = 1'b1;
			end
			OPC_BRANCH:
			begin
				case (w[14:12])
					3'd0: u.op = BEQ;
					3'd1: u.op = BNE;
					3'd4: u.op = BLT;
					3'd5: u.op = BGE;
					3'd6: u.op = BLTU;
					3'd7: u.op = BGEU;
					default: u.op = II;
				endcase
				{u.srcA, u.srcA_valid, u.srcB, u.srcB_valid} = {preg_t'(w[19:15]), 1'b1,
					preg_t'(w[24:20]), 1'b1};
				u.is_int = 1'b1;
			end
			OPC_JALR:
			begin
				u.op = rd_nz ? JALR : JR;
				{u.srcA, u.srcA_valid, u.is_int, u.is_br} = {preg_t'(w[19:15]), 3'b111};
				{u.dst, u.dst_valid} = rd_nz ? {preg_t'(w[11:7]), 1'b1} : '0;
				u.imm = pt[15:0];
				u.jmp_imm = pt[`M_WIDTH-1:16];
			end
			OPC_JAL:
			begin
				u.op = rd_nz ? JAL : J;
				{u.br_pred, u.is_br, u.is_int} = 3'b111;
				{u.dst, u.dst_valid} = rd_nz ? {preg_t'(w[11:7]), 1'b1} : '0;
			end
			OPC_SYSTEM:
			begin
				u.op = (w[31:7] == 25'd0) ? BREAK : NOP;
				u.serializing_op = (w[31:7] == 25'd0);
				u.is_int = 1'b1;
			end
			default:
				u.op = II;
		endcase
		// rd of x0 turns a result into nothing
		if (writes && !rd_nz && u.op != II)
			u.op = NOP;
		if (u.op == II)
			u = '0;
		u.rvimm = imm_ref(w);
		u.pc = fpc;
		u.pht_idx = pht;
		decode_ref = u;
	endfunction

	// outputs are settled by the falling edge
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			check_val("uop_valid", uop_valid, exp_valid);
			if (uop_valid && exp_q.size() == 0)
			begin
				$display("valid micro-op came out with no instruction pending");
				abort_run();
			end
			else if (uop_valid)
			begin
				exp_uop = exp_q.pop_front();
				held_uop = exp_uop;
				check_val("op", uop.op, exp_uop.op);
				check_val("srcA", uop.srcA, exp_uop.srcA);
				check_val("srcA_valid", uop.srcA_valid, exp_uop.srcA_valid);
				check_val("srcB", uop.srcB, exp_uop.srcB);
				check_val("srcB_valid", uop.srcB_valid, exp_uop.srcB_valid);
				check_val("dst", uop.dst, exp_uop.dst);
				check_val("dst_valid", uop.dst_valid, exp_uop.dst_valid);
				check_val("imm", uop.imm, exp_uop.imm);
				check_val("jmp_imm", uop.jmp_imm, exp_uop.jmp_imm);
				check_val("rvimm", uop.rvimm, exp_uop.rvimm);
				check_val("pc", uop.pc, exp_uop.pc);
				check_val("pht_idx", uop.pht_idx, exp_uop.pht_idx);
				check_val("serializing_op", uop.serializing_op, exp_uop.serializing_op);
				check_val("br_pred", uop.br_pred, exp_uop.br_pred);
				check_val("is_br", uop.is_br, exp_uop.is_br);
				check_val("is_mem", uop.is_mem, exp_uop.is_mem);
				check_val("is_int", uop.is_int, exp_uop.is_int);
				check_val("is_store", uop.is_store, exp_uop.is_store);
			end
			else
			begin
				// a bubble leaves the last micro-op in the register
				check_val("held op", uop.op, held_uop.op);
				check_val("held pc", uop.pc, held_uop.pc);
				check_val("held pht_idx", uop.pht_idx, held_uop.pht_idx);
				check_val("held rvimm", uop.rvimm, held_uop.rvimm);
			end
			// what was driven this cycle shows up next falling edge
			exp_valid = insn_valid;
		end
	end

	initial
	begin
		logic [31:0] directed [8];
		logic [31:0] word;
		logic [31:0] sel;
		logic [31:0] bits;
		logic [31:0] r_pc;
		logic [31:0] r_pht;
		logic [31:0] r_pt;
		int          wait_cnt;
		// break, ebreak, lw to x0, jalr x1, ret, j, sub, unknown opcode
		directed = '{32'h0000_0073, 32'h0010_0073, 32'h0000_2003, 32'h0000_00e7,
			32'h0000_8067, 32'h0000_006f, 32'h4000_0033, 32'h0000_007f};
		lfsr_q = 32'hfa01_0067;
		clk = 1'b0;
		rst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		pc = '0;
		pht_idx = '0;
		pred_target = '0;
		exp_valid = 1'b0;
		held_uop = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < 600; i++)
		begin
			@(posedge clk);
			take_bits(4, sel);
			take_bits(25, bits);
			word = {bits[24:0], (sel < 10) ? kept_opcode(sel[3:0]) : 7'd0};
			if (sel >= 10)
			begin
				take_bits(7, bits);
				word[6:0] = bits[6:0];
			end
			// bias towards x0 destinations and base register ops
			take_bits(2, bits);
			if (bits[1:0] == 2'd0)
				word[11:7] = 5'd0;
			if (bits[1] && word[6:0] == OPC_OP)
				word[31:25] = 7'd0;
			if (i < 8)
				word = directed[i];
			take_bits(32, r_pc);
			take_bits(12, r_pht);
			take_bits(32, r_pt);
			// gaps on roughly a quarter of the cycles
			take_bits(2, bits);
			insn_valid <= (i < 8) || (bits[1:0] != 2'd0);
			insn <= word;
			pc <= r_pc;
			pht_idx <= r_pht[`LG_PHT_SZ-1:0];
			pred_target <= r_pt;
			if ((i < 8) || (bits[1:0] != 2'd0))
				exp_q.push_back(decode_ref(word, r_pc, r_pht[`LG_PHT_SZ-1:0], r_pt));
		end
		@(posedge clk);
		insn_valid <= 1'b0;
		// drain whatever is still in the register
		wait_cnt = 0;
		while (exp_q.size() != 0 && wait_cnt < 20)
		begin
			@(posedge clk);
			wait_cnt++;
		end
		// one more falling edge sees the idle output
		@(negedge clk);
		@(posedge clk);
		if (exp_q.size() != 0)
		begin
			$display("timed out waiting for the last micro-ops to leave decode");
			abort_run();
		end
		else
		begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

// File: project.f
+incdir+hw
hw/decode_pkg.sv
hw/rv_imm_gen.sv
hw/rv_op_decode.sv
hw/decode_stage.sv
bench/decode_asserts.sv
bench/tb_decode_stage.sv
